//--- source/simplebus_cfg.svh
`ifndef SIMPLEBUS_CFG_SVH
`define SIMPLEBUS_CFG_SVH

// Bus word width, used for both address and data
`define SB_DATA_WIDTH 32

// Scratch RAM window, upper bound exclusive
`define SB_RAM_LOW  32'h0000_1000
`define SB_RAM_HIGH 32'h0000_1040

// Counter peripheral window, upper bound exclusive
`define SB_CNT_LOW  32'h0000_2000
`define SB_CNT_HIGH 32'h0000_2010

// Words held by the scratch RAM
`define SB_RAM_DEPTH 16

// Counter register word offsets
`define SB_CNT_CTRL    4'd0
`define SB_CNT_VALUE   4'd1
`define SB_CNT_COMPARE 4'd2
`define SB_CNT_STATUS  4'd3

`endif

//--- source/simplebus_pkg.sv
`include "simplebus_cfg.svh"

package simplebus_pkg;

        // Address split into region, word offset and byte lane
        typedef struct packed {
                logic [`SB_DATA_WIDTH-7:0] region;
                logic [3:0]                offset;
                logic [1:0]                byte_sel;
        } sb_address_fields_t;

        // Flat view for window compares, field view for register select
        typedef union packed {
                logic [`SB_DATA_WIDTH-1:0] flat;
                sb_address_fields_t        field;
        } sb_address_t;

endpackage

//--- source/simplebus_if.sv
`include "simplebus_cfg.svh"

interface simplebus_if import simplebus_pkg::*; ();

        // Request, driven by the interconnect
        sb_address_t               address;
        logic [`SB_DATA_WIDTH-1:0] write_data;
        logic                      write_strobe;
        logic                      read_strobe;

        // Response, driven by the slave
        logic [`SB_DATA_WIDTH-1:0] read_data;
        logic                      ready;

        modport master (
                output address,
                output write_data,
                output write_strobe,
                output read_strobe,
                input  read_data,
                input  ready
        );

        modport slave (
                input  address,
                input  write_data,
                input  write_strobe,
                input  read_strobe,
                output read_data,
                output ready
        );

endinterface

//--- source/simplebus_interconnect.sv
`include "simplebus_cfg.svh"

module simplebus_interconnect import simplebus_pkg::*; (
        input  logic                      clock,
        input  logic                      rst_n,
        input  sb_address_t               address,
        input  logic [`SB_DATA_WIDTH-1:0] write_data,
        input  logic                      write_strobe,
        input  logic                      read_strobe,
        output logic [`SB_DATA_WIDTH-1:0] read_data,
        output logic                      ready,
        simplebus_if.master               ram,
        simplebus_if.master               cnt
);

        logic ram_hit;
        logic cnt_hit;

        function automatic logic in_window(
                input logic [`SB_DATA_WIDTH-1:0] addr,
                input logic [`SB_DATA_WIDTH-1:0] low,
                input logic [`SB_DATA_WIDTH-1:0] high
        );
                return (addr >= low) && (addr < high);
        endfunction

        // Fixed windows, compared against the flat address
        assign ram_hit = in_window(address.flat, `SB_RAM_LOW, `SB_RAM_HIGH);
        assign cnt_hit = in_window(address.flat, `SB_CNT_LOW, `SB_CNT_HIGH);

        // Strobes reach only the link whose window matched
        always_ff @(posedge clock or negedge rst_n) begin
                if (!rst_n) begin
                        ram.write_strobe <= 1'b0;
                        ram.read_strobe  <= 1'b0;
                        cnt.write_strobe <= 1'b0;
                        cnt.read_strobe  <= 1'b0;
                end else begin
                        ram.write_strobe <= write_strobe & ram_hit;
                        ram.read_strobe  <= read_strobe & ram_hit;
                        cnt.write_strobe <= write_strobe & cnt_hit;
                        cnt.read_strobe  <= read_strobe & cnt_hit;
                end
        end

        // Payload slice, unselected link sees zeros
        always_ff @(posedge clock) begin
                ram.address    <= ram_hit ? address : '0;
                ram.write_data <= ram_hit ? write_data : '0;
                cnt.address    <= cnt_hit ? address : '0;
                cnt.write_data <= cnt_hit ? write_data : '0;
        end

        // Idle slaves return zero, so OR merges the responses
        always_ff @(posedge clock or negedge rst_n) begin
                if (!rst_n) begin
                        read_data <= '0;
                        ready     <= 1'b1;
                end else begin
                        read_data <= ram.read_data | cnt.read_data;
                        ready     <= ram.ready & cnt.ready;
                end
        end

        // Never more than one slave addressed per cycle
        a_single_link: assert property (
                @(posedge clock) disable iff (!rst_n)
                !((ram.write_strobe || ram.read_strobe) &&
                  (cnt.write_strobe || cnt.read_strobe))
        );

        // A master request is either a read or a write
        a_single_strobe: assert property (
                @(posedge clock) disable iff (!rst_n)
                !(write_strobe && read_strobe)
        );

endmodule

//--- source/scratch_ram.sv
`include "simplebus_cfg.svh"

module scratch_ram (
        input logic        clock,
        input logic        rst_n,
        simplebus_if.slave bus
);

        localparam int INDEX_BITS = $clog2(`SB_RAM_DEPTH);

        logic [`SB_DATA_WIDTH-1:0] mem [`SB_RAM_DEPTH];
        logic [INDEX_BITS-1:0]     word_index;

        // Word select from the offset field
        assign word_index = bus.address.field.offset[INDEX_BITS-1:0];

        always_ff @(posedge clock or negedge rst_n) begin
                if (!rst_n) begin
                        for (int i = 0; i < `SB_RAM_DEPTH; i++) begin
                                mem[i] <= '0;
                        end
                        bus.read_data <= '0;
                        bus.ready     <= 1'b1;
                end else begin
                        if (bus.write_strobe) begin
                                mem[word_index] <= bus.write_data;
                        end
                        // Data only in the cycle after a read
                        bus.read_data <= bus.read_strobe ? mem[word_index] : '0;
                        // Busy for one cycle while the write commits
                        bus.ready <= !bus.write_strobe;
                end
        end

        // Master must hold off while the commit is in progress
        a_no_access_busy: assert property (
                @(posedge clock) disable iff (!rst_n)
                !bus.ready |-> !(bus.write_strobe || bus.read_strobe)
        );

endmodule

//--- source/counter_peripheral.sv
`include "simplebus_cfg.svh"

module counter_peripheral (
        input logic        clock,
        input logic        rst_n,
        simplebus_if.slave bus
);

        logic                      enable;
        logic [`SB_DATA_WIDTH-1:0] value;
        logic [`SB_DATA_WIDTH-1:0] compare;
        logic                      match;
        logic                      hit;
        logic                      wr_ctrl;
        logic                      wr_value;
        logic                      wr_compare;
        logic                      clear_match;
        logic [`SB_DATA_WIDTH-1:0] reg_view;

        // Register write decode
        assign wr_ctrl    = bus.write_strobe && (bus.address.field.offset == `SB_CNT_CTRL);
        assign wr_value   = bus.write_strobe && (bus.address.field.offset == `SB_CNT_VALUE);
        assign wr_compare = bus.write_strobe && (bus.address.field.offset == `SB_CNT_COMPARE);

        // Status is write-one-to-clear
        assign clear_match = bus.write_strobe && bus.write_data[0] &&
                             (bus.address.field.offset == `SB_CNT_STATUS);

        assign hit = enable && (value == compare);

        always_ff @(posedge clock or negedge rst_n) begin
                if (!rst_n) begin
                        enable  <= 1'b0;
                        value   <= '0;
                        compare <= '0;
                        match   <= 1'b0;
                end else begin
                        if (wr_ctrl) begin
                                enable <= bus.write_data[0];
                        end
                        // Load has priority over counting
                        if (wr_value) begin
                                value <= bus.write_data;
                        end else if (enable) begin
                                value <= value + 1'b1;
                        end
                        if (wr_compare) begin
                                compare <= bus.write_data;
                        end
                        // New match wins over a clear in the same cycle
                        match <= hit | (match & !clear_match);
                end
        end

        // Read mux over the four registers
        always_comb begin
                case (bus.address.field.offset)
                        `SB_CNT_CTRL:    reg_view = {{(`SB_DATA_WIDTH-1){1'b0}}, enable};
                        `SB_CNT_VALUE:   reg_view = value;
                        `SB_CNT_COMPARE: reg_view = compare;
                        `SB_CNT_STATUS:  reg_view = {{(`SB_DATA_WIDTH-1){1'b0}}, match};
                        default:         reg_view = '0;
                endcase
        end

        always_ff @(posedge clock or negedge rst_n) begin
                if (!rst_n) begin
                        bus.read_data <= '0;
                end else begin
                        bus.read_data <= bus.read_strobe ? reg_view : '0;
                end
        end

        // Never busy
        assign bus.ready = 1'b1;

endmodule

//--- source/simplebus_subsystem.sv
`include "simplebus_cfg.svh"

module simplebus_subsystem (
        input  logic                      clock,
        input  logic                      rst_n,
        input  logic [`SB_DATA_WIDTH-1:0] address,
        input  logic [`SB_DATA_WIDTH-1:0] write_data,
        input  logic                      write_strobe,
        input  logic                      read_strobe,
        output logic [`SB_DATA_WIDTH-1:0] read_data,
        output logic                      ready
);

        // One link per slave
        simplebus_if ram_link ();
        simplebus_if cnt_link ();

        simplebus_interconnect u_interconnect (
                .clock        (clock),
                .rst_n        (rst_n),
                .address      (address),
                .write_data   (write_data),
                .write_strobe (write_strobe),
                .read_strobe  (read_strobe),
                .read_data    (read_data),
                .ready        (ready),
                .ram          (ram_link.master),
                .cnt          (cnt_link.master)
        );

        scratch_ram u_scratch_ram (
                .clock (clock),
                .rst_n (rst_n),
                .bus   (ram_link.slave)
        );

        counter_peripheral u_counter (
                .clock (clock),
                .rst_n (rst_n),
                .bus   (cnt_link.slave)
        );

endmodule

//--- dv/clock_gen.sv
module clock_gen (
        output logic clock,
        output logic rst_n
);

        timeunit 1ns;
        timeprecision 100ps;

        localparam int HALF_PERIOD  = 5;
        localparam int RESET_CYCLES = 8;

        initial begin
                clock = 1'b0;
                forever #HALF_PERIOD clock = ~clock;
        end

        // Release away from the edge so the flops see a clean deassert
        initial begin
                rst_n = 1'b0;
                repeat (RESET_CYCLES) @(posedge clock);
                #2;
                rst_n = 1'b1;
        end

endmodule

//--- dv/simplebus_tb.sv
`include "simplebus_cfg.svh"

module simplebus_tb;

        timeunit 1ns;
        timeprecision 100ps;

        localparam string CASES_FILE = "dv/simplebus_cases.txt";
        // Result is on the bus from the third edge after the strobe is driven
        localparam int CHECK_OFFSET = 3;

        logic                      clock;
        logic                      rst_n;
        logic [`SB_DATA_WIDTH-1:0] address;
        logic [`SB_DATA_WIDTH-1:0] write_data;
        logic                      write_strobe;
        logic                      read_strobe;
        logic [`SB_DATA_WIDTH-1:0] read_data;
        logic                      ready;

        // Accesses as read from the cases file
        logic [7:0]                case_op[$];
        logic [`SB_DATA_WIDTH-1:0] case_addr[$];
        logic [`SB_DATA_WIDTH-1:0] case_wdata[$];
        logic [`SB_DATA_WIDTH-1:0] case_exp[$];
        int                        case_test[$];
        int                        case_gap[$];

        // Reads still waiting for their result
        int                        pend_due[$];
        logic [`SB_DATA_WIDTH-1:0] pend_exp[$];
        logic [`SB_DATA_WIDTH-1:0] pend_addr[$];

        int   cycle_count = 0;
        int   cycle_limit = 0;
        int   checks = 0;
        int   errors = 0;
        int   test_errors = 0;
        int   tests_passed = 0;
        int   tests_failed = 0;
        logic cases_loaded;

        clock_gen u_clock_gen (
                .clock (clock),
                .rst_n (rst_n)
        );

        simplebus_subsystem dut (
                .clock        (clock),
                .rst_n        (rst_n),
                .address      (address),
                .write_data   (write_data),
                .write_strobe (write_strobe),
                .read_strobe  (read_strobe),
                .read_data    (read_data),
                .ready        (ready)
        );

        function automatic logic in_ram_window(input logic [`SB_DATA_WIDTH-1:0] addr);
                return (addr >= `SB_RAM_LOW) && (addr < `SB_RAM_HIGH);
        endfunction

        task automatic load_cases(output logic ok);
                int                        fd;
                int                        fields;
                int                        bad_lines;
                string                     line;
                logic [7:0]                op;
                logic [`SB_DATA_WIDTH-1:0] addr_v;
                logic [`SB_DATA_WIDTH-1:0] wdata_v;
                logic [`SB_DATA_WIDTH-1:0] exp_v;
                int                        test_v;
                int                        gap_v;
                bad_lines = 0;
                fd = $fopen(CASES_FILE, "r");
                if (fd != 0) begin
                        while ($fgets(line, fd) != 0) begin
                                if (line.len() < 2 || line[0] == "#") continue;
                                fields = $sscanf(line, "%c %h %h %h %d %d",
                                                 op, addr_v, wdata_v, exp_v, test_v, gap_v);
                                if (fields != 6 || (op != "W" && op != "R")) begin
                                        $display("Cases file line not understood: %s", line);
                                        bad_lines++;
                                end else begin
                                        case_op.push_back(op);
                                        case_addr.push_back(addr_v);
                                        case_wdata.push_back(wdata_v);
                                        case_exp.push_back(exp_v);
                                        case_test.push_back(test_v);
                                        case_gap.push_back(gap_v);
                                end
                        end
                        $fclose(fd);
                end
                ok = (fd != 0) && (bad_lines == 0) && (case_op.size() > 0);
        endtask

        // Every cycle starts idle, so a strobe lasts one cycle
        task automatic next_cycle();
                @(posedge clock);
                #1;
                write_strobe = 1'b0;
                read_strobe  = 1'b0;
                address      = '0;
                write_data   = '0;
        endtask

        // RAM write commit shows as one low cycle of ready, three edges on
        task automatic check_write_busy(input int issued_at, input logic [31:0] addr);
                while (cycle_count < issued_at + CHECK_OFFSET) next_cycle();
                checks++;
                if (ready !== 1'b0) begin
                        $display("Error at %t: ready expected 0, got %b after write to %h",
                                 $time, ready, addr);
                        test_errors++;
                end
        endtask

        task automatic issue(input int i);
                int issued_at;
                next_cycle();
                repeat (case_gap[i]) next_cycle();
                // Hold the strobe while the bus is busy
                while (ready !== 1'b1) next_cycle();
                address    = case_addr[i];
                write_data = case_wdata[i];
                issued_at  = cycle_count;
                if (case_op[i] == "R") begin
                        read_strobe = 1'b1;
                        pend_due.push_back(issued_at + CHECK_OFFSET);
                        pend_exp.push_back(case_exp[i]);
                        pend_addr.push_back(case_addr[i]);
                end else begin
                        write_strobe = 1'b1;
                        if (in_ram_window(case_addr[i])) begin
                                check_write_busy(issued_at, case_addr[i]);
                        end
                end
        endtask

        task automatic finish_test(input int test_num);
                // Outstanding reads come back before the verdict
                while (pend_due.size() > 0) next_cycle();
                if (test_errors == 0) begin
                        $display("Test %0d passed", test_num);
                        tests_passed++;
                end else begin
                        $display("Test %0d failed with %0d errors", test_num, test_errors);
                        tests_failed++;
                end
                errors += test_errors;
                test_errors = 0;
        endtask

        task automatic run_cases();
                wait (rst_n === 1'b1);
                @(posedge clock);
                #1;
                checks++;
                if (ready !== 1'b1) begin
                        $display("Error at %t: ready expected 1, got %b after reset", $time, ready);
                        test_errors++;
                end
                for (int i = 0; i < case_op.size(); i++) begin
                        if (i > 0 && case_test[i] != case_test[i-1]) begin
                                finish_test(case_test[i-1]);
                                repeat ($urandom_range(3)) next_cycle();
                        end
                        issue(i);
                end
                finish_test(case_test[case_op.size()-1]);
        endtask

        // Read results are compared once the edge has settled
        always @(posedge clock) begin
                cycle_count++;
                #2;
                while (pend_due.size() > 0 && pend_due[0] == cycle_count) begin
                        checks++;
                        if (read_data !== pend_exp[0]) begin
                                $display("Error at %t: read_data expected %h, got %h (address %h)",
                                         $time, pend_exp[0], read_data, pend_addr[0]);
                                test_errors++;
                        end
                        void'(pend_due.pop_front());
                        void'(pend_exp.pop_front());
                        void'(pend_addr.pop_front());
                end
        end

        initial begin
                wait (cycle_limit > 0 && cycle_count >= cycle_limit);
                $display("Run stopped: %0d cycles passed before the cases finished", cycle_limit);
                $display("Finished with errors");
                $finish;
        end

        initial begin
                address      = '0;
                write_data   = '0;
                write_strobe = 1'b0;
                read_strobe  = 1'b0;
                $timeformat(-9, 1, " ns", 0);
                // Seed once for the idle gaps between tests
                void'($urandom(23));
                load_cases(cases_loaded);
                if (cases_loaded) begin
                        cycle_limit = case_op.size() * 8 + 200;
                        run_cases();
                end else begin
                        $display("Cases file %s could not be read", CASES_FILE);
                        errors++;
                end
                $display("Tests passed: %0d, tests failed: %0d, checks: %0d, errors: %0d",
                         tests_passed, tests_failed, checks, errors);
                if (errors == 0) begin
                        $display("Finished with no errors");
                end else begin
                        $display("Finished with errors");
                end
                $finish;
        end

endmodule

//--- dv/simplebus_cases.txt
# op(W/R) address(hex) write_data(hex) expected_read_data(hex, ignored for W) test gap
# gap is the number of idle cycles before the access
R 00001000 00000000 00000000 1 0
R 00001004 00000000 00000000 1 0
R 00001008 00000000 00000000 1 0
R 0000100c 00000000 00000000 1 0
R 00001010 00000000 00000000 1 0
R 00001014 00000000 00000000 1 0
R 00001018 00000000 00000000 1 0
R 0000101c 00000000 00000000 1 0
R 00001020 00000000 00000000 1 0
R 00001024 00000000 00000000 1 0
R 00001028 00000000 00000000 1 0
R 0000102c 00000000 00000000 1 0
R 00001030 00000000 00000000 1 0
R 00001034 00000000 00000000 1 0
R 00001038 00000000 00000000 1 0
R 0000103c 00000000 00000000 1 0
R 00002000 00000000 00000000 1 0
R 00002004 00000000 00000000 1 0
R 00002008 00000000 00000000 1 0
R 0000200c 00000000 00000000 1 0
W 00001000 a5a50001 00000000 2 0
W 00001014 12345678 00000000 2 0
W 0000103c deadbeef 00000000 2 0
W 00001020 000000ff 00000000 2 0
R 00001000 00000000 a5a50001 2 0
R 00001014 00000000 12345678 2 0
R 0000103c 00000000 deadbeef 2 0
R 00001020 00000000 000000ff 2 0
R 00001004 00000000 00000000 2 0
W 00001008 0badf00d 00000000 3 0
R 00001008 00000000 0badf00d 3 0
W 0000100c 600dcafe 00000000 3 0
W 00001010 00c0ffee 00000000 3 0
R 00001040 00000000 00000000 4 0
R 00000ffc 00000000 00000000 4 0
R 00002010 00000000 00000000 4 0
R 00000000 00000000 00000000 4 0
W 00001040 ffffffff 00000000 4 0
W 00000ffc ffffffff 00000000 4 0
R 00001000 00000000 a5a50001 4 0
R 0000103c 00000000 deadbeef 4 0
W 00002004 00000100 00000000 5 0
W 00002000 00000001 00000000 5 0
R 00002004 00000000 00000105 5 5
W 00002000 00000000 00000000 5 2
R 00002004 00000000 00000109 5 3
R 00002004 00000000 00000109 5 0
W 00002004 00000200 00000000 6 0
W 00002008 00000203 00000000 6 0
R 0000200c 00000000 00000000 6 0
W 00002000 00000001 00000000 6 0
R 0000200c 00000000 00000001 6 6
W 00002000 00000000 00000000 6 0
W 0000200c 00000001 00000000 6 0
R 0000200c 00000000 00000000 6 0
R 00002008 00000000 00000203 6 0

//--- tb.f
+incdir+source
source/simplebus_pkg.sv
source/simplebus_if.sv
source/simplebus_interconnect.sv
source/scratch_ram.sv
source/counter_peripheral.sv
source/simplebus_subsystem.sv
dv/clock_gen.sv
dv/simplebus_tb.sv
